/* hdl/lrelu_pkg.sv */
package lrelu_pkg;

  // array geometry
  localparam int GROUPS      = 2;
  localparam int UNITS       = 4;
  localparam int LANES       = GROUPS * UNITS;
  localparam int GROUP_WIDTH = $clog2(GROUPS);
  localparam int STAGES      = 3;

  // word widths
  localparam int IN_WIDTH   = 24;
  localparam int OUT_WIDTH  = 8;
  localparam int COEF_WIDTH = 16;
  localparam int ACC_WIDTH  = 40;

  // fixed point formats, A is Q8.8 and the leak slope is 13/128
  localparam int A_FRAC     = 8;
  localparam int ALPHA      = 13;
  localparam int ALPHA_FRAC = 7;

  // output saturation bounds
  localparam int OUT_MAX = 2 ** (OUT_WIDTH - 1) - 1;
  localparam int OUT_MIN = -(2 ** (OUT_WIDTH - 1));

  // coefficient table
  localparam int MEMBERS     = 8;
  localparam int INDEX_WIDTH = 3;
  localparam int KW2_WIDTH   = 2;

  typedef enum logic [1:0] {
    CFG_A = 2'd0,
    CFG_B = 2'd1,
    CFG_D = 2'd2
  } cfg_kind_t;

  typedef struct packed {
    cfg_kind_t                      kind;
    logic [GROUP_WIDTH-1:0]         group;
    logic [INDEX_WIDTH-1:0]         addr;
    logic signed [COEF_WIDTH-1:0]   value;
  } cfg_word_t;

  typedef struct packed {
    logic                   is_lrelu;
    logic [KW2_WIDTH-1:0]   kw2;
  } user_t;

  typedef struct packed {
    logic [LANES-1:0][IN_WIDTH-1:0] data;
    user_t                          user;
    logic                           last;
  } in_beat_t;

  typedef struct packed {
    logic signed [COEF_WIDTH-1:0] a;
    logic signed [COEF_WIDTH-1:0] b;
  } coef_t;

  typedef coef_t [GROUPS-1:0] group_coef_t;

  typedef logic [GROUPS-1:0][COEF_WIDTH-1:0] offset_row_t;

  // stage 0 payload
  typedef struct packed {
    in_beat_t     beat;
    group_coef_t  coef;
    offset_row_t  offset;
  } lookup_beat_t;

  typedef struct packed {
    logic [LANES-1:0][ACC_WIDTH-1:0] value;
    logic                            is_lrelu;
    logic                            last;
    offset_row_t                     offset;
  } affine_beat_t;

  typedef struct packed {
    logic [LANES-1:0][OUT_WIDTH-1:0] data;
    logic                            last;
  } out_beat_t;

endpackage

/* hdl/lrelu_pipe_reg.sv */
`timescale 1ns/1ps

module lrelu_pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_n,

  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,

  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  logic load;

  // accept when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

/* hdl/lrelu_config_store.sv */
`timescale 1ns/1ps

module lrelu_config_store (
  input  logic                          clk,
  input  logic                          rst_n,

  // config write port
  input  logic                          cfg_valid,
  output logic                          cfg_ready,
  input  lrelu_pkg::cfg_word_t          cfg,

  // held-valid bits of the three stages
  input  logic [lrelu_pkg::STAGES-1:0]  in_flight,

  // input handshake and the fields that steer the index
  input  logic                          advance,
  input  logic [lrelu_pkg::KW2_WIDTH-1:0] kw2,
  input  logic                          last,

  output lrelu_pkg::group_coef_t        coef,
  output lrelu_pkg::offset_row_t        offset
);

  import lrelu_pkg::*;

  logic signed [COEF_WIDTH-1:0] a_mem [GROUPS][MEMBERS];
  logic signed [COEF_WIDTH-1:0] b_mem [GROUPS][MEMBERS];
  offset_row_t                  d_reg;

  logic [INDEX_WIDTH-1:0] index;
  logic [INDEX_WIDTH-1:0] limit_lut [2 ** KW2_WIDTH];
  logic                   cfg_write;

  // no writes while any beat is inside the pipeline
  assign cfg_ready = ~|in_flight;
  assign cfg_write = cfg_valid && cfg_ready;

  // wrap limit MEMBERS/kw - 1 for kw = 2*kw2 + 1
  for (genvar k = 0; k < 2 ** KW2_WIDTH; k++) begin : g_limit
    assign limit_lut[k] = INDEX_WIDTH'(MEMBERS / (2 * k + 1) - 1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int g = 0; g < GROUPS; g++) begin
        for (int m = 0; m < MEMBERS; m++) begin
          a_mem[g][m] <= '0;
          b_mem[g][m] <= '0;
        end
      end
      d_reg <= '0;
    end else if (cfg_write) begin
      case (cfg.kind)
        CFG_A: a_mem[cfg.group][cfg.addr] <= cfg.value;
        CFG_B: b_mem[cfg.group][cfg.addr] <= cfg.value;
        // one offset per group, addr unused
        CFG_D: d_reg[cfg.group] <= cfg.value;
        default: begin
        end
      endcase
    end
  end

  // cyclic read pointer, steps on every accepted beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index <= '0;
    end else if (advance) begin
      if (last || index == limit_lut[kw2]) begin
        index <= '0;
      end else begin
        index <= index + 1'b1;
      end
    end
  end

  // lookup at the index held before the beat is accepted
  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      coef[g].a = a_mem[g][index];
      coef[g].b = b_mem[g][index];
    end
  end

  assign offset = d_reg;

endmodule

/* hdl/lrelu_affine_stage.sv */
`timescale 1ns/1ps

module lrelu_affine_stage (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    in_valid,
  output logic                    in_ready,
  input  lrelu_pkg::lookup_beat_t in_beat,

  output logic                    out_valid,
  input  logic                    out_ready,
  output lrelu_pkg::affine_beat_t out_beat,

  output logic                    held
);

  import lrelu_pkg::*;

  logic signed [ACC_WIDTH-1:0] product [LANES];
  affine_beat_t                result;

  // r1 = floor(x * a / 2^A_FRAC) + b, lane l belongs to group l / UNITS
  always_comb begin
    result.is_lrelu = in_beat.beat.user.is_lrelu;
    result.last     = in_beat.beat.last;
    result.offset   = in_beat.offset;
    for (int l = 0; l < LANES; l++) begin
      product[l] = $signed(in_beat.beat.data[l]) * $signed(in_beat.coef[l / UNITS].a);
      // arithmetic shift keeps the floor for negative products
      result.value[l] = (product[l] >>> A_FRAC) + $signed(in_beat.coef[l / UNITS].b);
    end
  end

  lrelu_pipe_reg #(
    .T (affine_beat_t)
  ) affine_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (result),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_beat)
  );

  assign held = out_valid;

endmodule

/* hdl/lrelu_activation_stage.sv */
`timescale 1ns/1ps

module lrelu_activation_stage (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    in_valid,
  output logic                    in_ready,
  input  lrelu_pkg::affine_beat_t in_beat,

  output logic                    out_valid,
  input  logic                    out_ready,
  output lrelu_pkg::out_beat_t    out_beat,

  output logic                    held
);

  import lrelu_pkg::*;

  logic signed [ACC_WIDTH-1:0] r1 [LANES];
  logic signed [ACC_WIDTH-1:0] r2 [LANES];
  logic signed [ACC_WIDTH-1:0] r3 [LANES];
  out_beat_t                   result;

  always_comb begin
    result.last = in_beat.last;
    for (int l = 0; l < LANES; l++) begin
      r1[l] = $signed(in_beat.value[l]);
      // leak only on negative values, and only when the user flag asks for it
      if (in_beat.is_lrelu && r1[l] < 0) begin
        r2[l] = (r1[l] * ALPHA) >>> ALPHA_FRAC;
      end else begin
        r2[l] = r1[l];
      end
      r3[l] = r2[l] + $signed(in_beat.offset[l / UNITS]);
      // clamp to the signed output range
      if (r3[l] > OUT_MAX) begin
        result.data[l] = OUT_WIDTH'(OUT_MAX);
      end else if (r3[l] < OUT_MIN) begin
        result.data[l] = OUT_WIDTH'(OUT_MIN);
      end else begin
        result.data[l] = r3[l][OUT_WIDTH-1:0];
      end
    end
  end

  lrelu_pipe_reg #(
    .T (out_beat_t)
  ) out_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (result),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_beat)
  );

  assign held = out_valid;

endmodule

/* hdl/lrelu_engine.sv */
`timescale 1ns/1ps

module lrelu_engine (
  input  logic                  clk,
  input  logic                  rst_n,

  // accumulator stream in
  input  logic                  s_valid,
  output logic                  s_ready,
  input  lrelu_pkg::in_beat_t   s_beat,

  // activation stream out
  output logic                  m_valid,
  input  logic                  m_ready,
  output lrelu_pkg::out_beat_t  m_beat,

  // coefficient load
  input  logic                  cfg_valid,
  output logic                  cfg_ready,
  input  lrelu_pkg::cfg_word_t  cfg
);

  import lrelu_pkg::*;

  group_coef_t  coef;
  offset_row_t  offset;
  lookup_beat_t lookup;
  logic         advance;

  lookup_beat_t stage0_beat;
  logic         stage0_valid;
  logic         stage0_ready;

  affine_beat_t affine_beat;
  logic         affine_valid;
  logic         affine_ready;
  logic         affine_held;
  logic         act_held;

  assign advance = s_valid && s_ready;

  assign lookup.beat   = s_beat;
  assign lookup.coef   = coef;
  assign lookup.offset = offset;

  lrelu_config_store config_store_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg       (cfg),
    .in_flight ({act_held, affine_held, stage0_valid}),
    .advance   (advance),
    .kw2       (s_beat.user.kw2),
    .last      (s_beat.last),
    .coef      (coef),
    .offset    (offset)
  );

  // stage 0 captures the beat with its coefficients
  lrelu_pipe_reg #(
    .T (lookup_beat_t)
  ) lookup_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .in_data   (lookup),
    .out_valid (stage0_valid),
    .out_ready (stage0_ready),
    .out_data  (stage0_beat)
  );

  lrelu_affine_stage affine_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (stage0_valid),
    .in_ready  (stage0_ready),
    .in_beat   (stage0_beat),
    .out_valid (affine_valid),
    .out_ready (affine_ready),
    .out_beat  (affine_beat),
    .held      (affine_held)
  );

  lrelu_activation_stage activation_stage_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (affine_valid),
    .in_ready  (affine_ready),
    .in_beat   (affine_beat),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_beat  (m_beat),
    .held      (act_held)
  );

endmodule

/* dv/lrelu_engine_tb.sv */
`timescale 1ns/1ps

module lrelu_engine_tb;

  import lrelu_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RANDOM_BEATS = 200;
  // directed tests with their table loads, then a few cycles per random beat
  localparam int WATCHDOG_CYCLES = 800 + RANDOM_BEATS * 6;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      s_valid;
  logic      s_ready;
  in_beat_t  s_beat;
  logic      m_valid;
  logic      m_ready;
  out_beat_t m_beat;
  logic      cfg_valid;
  logic      cfg_ready;
  cfg_word_t cfg;

  int        seed = 32'h5f0b_1426;
  int        errors;
  int        errors_base;
  int        tests_run;
  int        tests_bad;
  int        cycle;
  int        outstanding;
  int        model_idx;
  bit        check_latency;
  string     cur_test;
  // shadow copies of the coefficient tables
  int        sh_a [GROUPS][MEMBERS];
  int        sh_b [GROUPS][MEMBERS];
  int        sh_d [GROUPS];
  out_beat_t exp_q[$];
  int        acc_q[$];

  lrelu_engine lrelu_engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .s_beat    (s_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready),
    .m_beat    (m_beat),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg       (cfg)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic longint floor_div(input longint n, input longint d);
    longint q;
    q = n / d;
    if (n % d != 0 && ((n < 0) != (d < 0))) begin
      q = q - 1;
    end
    return q;
  endfunction

  // reference model of one beat at table index idx
  function automatic out_beat_t model_beat(input in_beat_t b, input int idx);
    out_beat_t o;
    longint    r;
    int        g;
    o.last = b.last;
    for (int l = 0; l < LANES; l++) begin
      g = l / UNITS;
      r = floor_div(longint'($signed(b.data[l])) * sh_a[g][idx], 256) + sh_b[g][idx];
      if (b.user.is_lrelu && r < 0) begin
        r = floor_div(r * 13, 128);
      end
      r = r + sh_d[g];
      if (r > 127) begin
        r = 127;
      end else if (r < -128) begin
        r = -128;
      end
      o.data[l] = OUT_WIDTH'(r);
    end
    return o;
  endfunction

  function automatic int next_index(input int idx, input in_beat_t b);
    int kw;
    kw = int'(b.user.kw2);
    if (b.last || idx == MEMBERS / (2 * kw + 1) - 1) begin
      return 0;
    end
    // the index only spans the table depth
    return (idx + 1) % MEMBERS;
  endfunction

  function automatic in_beat_t make_beat(input int base, input int step, input bit lrelu,
                                         input int kw2, input bit last);
    in_beat_t b;
    for (int l = 0; l < LANES; l++) begin
      b.data[l] = IN_WIDTH'(base + step * l);
    end
    b.user.is_lrelu = lrelu;
    b.user.kw2      = KW2_WIDTH'(kw2);
    b.last          = last;
    return b;
  endfunction

  function automatic in_beat_t random_beat();
    in_beat_t b;
    for (int l = 0; l < LANES; l++) begin
      b.data[l] = IN_WIDTH'($random(seed) % 512);
    end
    b.user.is_lrelu = 1'($random(seed));
    b.user.kw2      = KW2_WIDTH'($random(seed));
    b.last          = (($random(seed) & 15) == 0);
    return b;
  endfunction

  task automatic apply_cfg(input cfg_word_t w);
    case (w.kind)
      CFG_A: sh_a[w.group][w.addr] = int'(w.value);
      CFG_B: sh_b[w.group][w.addr] = int'(w.value);
      CFG_D: sh_d[w.group] = int'(w.value);
      default: ;
    endcase
  endtask

  task automatic check_output();
    out_beat_t exp;
    int        acc;
    assert (exp_q.size() != 0) else begin
      $display("%s: output beat arrived with no beat pending", cur_test);
      errors++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      acc = acc_q.pop_front();
      assert (m_beat == exp) else begin
        $display("MISMATCH %s: expected %h, actual %h", cur_test, exp, m_beat);
        errors++;
      end
      if (check_latency) begin
        assert (cycle - acc == 3) else begin
          $display("MISMATCH %s latency: expected 3, actual %0d", cur_test, cycle - acc);
          errors++;
        end
      end
    end
  endtask

  // handshakes sampled mid-cycle, they complete on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      assert (cfg_ready == (outstanding == 0)) else begin
        $display("%s: cfg_ready is %0b with %0d beats in flight", cur_test, cfg_ready,
                 outstanding);
        errors++;
      end
      // input stalls only with all stages full and the output stalled
      assert (s_ready == !(outstanding == STAGES && !m_ready)) else begin
        $display("%s: s_ready is %0b with %0d beats in flight", cur_test, s_ready, outstanding);
        errors++;
      end
      if (s_valid && s_ready) begin
        exp_q.push_back(model_beat(s_beat, model_idx));
        acc_q.push_back(cycle);
        model_idx = next_index(model_idx, s_beat);
        outstanding++;
      end
      if (cfg_valid && cfg_ready) begin
        apply_cfg(cfg);
      end
      if (m_valid && m_ready) begin
        check_output();
        outstanding--;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_beat(input in_beat_t b);
    s_beat  = b;
    s_valid = 1'b1;
    @(negedge clk);
    while (!s_ready) begin
      @(negedge clk);
    end
    next_cycle();
    s_valid = 1'b0;
  endtask

  task automatic write_cfg(input cfg_kind_t kind, input int group, input int addr,
                           input int value);
    cfg.kind  = kind;
    cfg.group = GROUP_WIDTH'(group);
    cfg.addr  = INDEX_WIDTH'(addr);
    cfg.value = COEF_WIDTH'(value);
    cfg_valid = 1'b1;
    @(negedge clk);
    while (!cfg_ready) begin
      @(negedge clk);
    end
    next_cycle();
    cfg_valid = 1'b0;
  endtask

  task automatic load_tables(input int a_base, input int a_step, input int b_group,
                             input int b_step);
    for (int g = 0; g < GROUPS; g++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        write_cfg(CFG_A, g, m, a_base + a_step * m);
        write_cfg(CFG_B, g, m, b_group * g + b_step * m);
      end
    end
  endtask

  task automatic set_offsets(input int d0, input int d1);
    write_cfg(CFG_D, 0, 0, d0);
    write_cfg(CFG_D, 1, 0, d1);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    errors_base = errors;
  endtask

  task automatic end_test();
    int bad;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    next_cycle();
    bad = errors - errors_base;
    tests_run++;
    if (bad != 0) begin
      tests_bad++;
    end
    $display("test %-18s %s, %0d errors", cur_test, (bad == 0) ? "ok" : "FAIL", bad);
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    @(negedge clk);
    assert (!m_valid && s_ready && cfg_ready) else begin
      $display("%s: after reset m_valid %0b s_ready %0b cfg_ready %0b", cur_test, m_valid,
               s_ready, cfg_ready);
      errors++;
    end
    next_cycle();
    // zero tables give zero lanes, last also puts the index back to 0
    send_beat(make_beat(5000, -1700, 1'b1, 0, 1'b1));
    end_test();
  endtask

  task automatic test_table_walk();
    start_test("table_walk");
    load_tables(256, 256, 5, -3);
    check_latency = 1'b1;
    // nine beats back to back, the ninth wraps to entry 0
    for (int n = 0; n < MEMBERS + 1; n++) begin
      send_beat(make_beat(4, 1, 1'b0, 0, 1'b0));
    end
    end_test();
    check_latency = 1'b0;
  endtask

  task automatic test_leaky_relu();
    start_test("leaky_relu");
    load_tables(256, 0, 0, 0);
    send_beat(make_beat(-600, 150, 1'b1, 0, 1'b0));
    send_beat(make_beat(-600, 150, 1'b0, 0, 1'b0));
    send_beat(make_beat(-9, 3, 1'b1, 0, 1'b0));
    send_beat(make_beat(-9, 3, 1'b0, 0, 1'b0));
    end_test();
  endtask

  task automatic test_offset_saturation();
    start_test("offset_saturation");
    set_offsets(1000, -1000);
    send_beat(make_beat(-100000, 30000, 1'b0, 0, 1'b0));
    // small inputs, the offset alone drives each lane into the clamp
    send_beat(make_beat(-20, 10, 1'b0, 0, 1'b0));
    set_offsets(20, -30);
    send_beat(make_beat(-20, 10, 1'b0, 0, 1'b0));
    end_test();
  endtask

  task automatic test_index_limit();
    start_test("index_limit");
    load_tables(256, 256, 5, -3);
    set_offsets(0, 0);
    send_beat(make_beat(4, 1, 1'b0, 0, 1'b1));
    repeat (4) send_beat(make_beat(4, 1, 1'b0, 1, 1'b0));
    repeat (2) send_beat(make_beat(4, 1, 1'b0, 2, 1'b0));
    // three beat frame, the next frame starts over at entry 0
    repeat (2) send_beat(make_beat(4, 1, 1'b0, 0, 1'b0));
    send_beat(make_beat(4, 1, 1'b0, 0, 1'b1));
    send_beat(make_beat(4, 1, 1'b0, 0, 1'b0));
    end_test();
  endtask

  task automatic test_backpressure();
    int sent;
    bit accepted;
    start_test("backpressure");
    for (int g = 0; g < GROUPS; g++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        write_cfg(CFG_A, g, m, $random(seed) % 384);
        write_cfg(CFG_B, g, m, $random(seed) % 64);
      end
    end
    set_offsets(7, -12);
    sent = 0;
    while (sent < RANDOM_BEATS) begin
      m_ready = 1'($random(seed));
      if (!s_valid && (($random(seed) & 3) != 0)) begin
        s_beat  = random_beat();
        s_valid = 1'b1;
      end
      @(negedge clk);
      accepted = s_valid && s_ready;
      if (accepted) begin
        sent++;
      end
      next_cycle();
      if (accepted) begin
        s_valid = 1'b0;
      end
    end
    m_ready = 1'b1;
    end_test();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, cur_test);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    s_valid   = 1'b0;
    s_beat    = '0;
    m_ready   = 1'b1;
    cfg_valid = 1'b0;
    cfg       = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_table_walk();
    test_leaky_relu();
    test_offset_saturation();
    test_index_limit();
    test_backpressure();
    $display("summary: %0d tests, %0d with errors, %0d failed checks", tests_run, tests_bad,
             errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* list.f */
hdl/lrelu_pkg.sv
hdl/lrelu_pipe_reg.sv
hdl/lrelu_config_store.sv
hdl/lrelu_affine_stage.sv
hdl/lrelu_activation_stage.sv
hdl/lrelu_engine.sv
dv/lrelu_engine_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lrelu_engine_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Testbench failed" $(LOG); then \
		echo "failure reported in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
